/* tile_pkg.sv */
package tile_pkg;

	// board geometry
	localparam int unsigned NUM_CELLS = 16;
	localparam int unsigned TILE_W = 4; // exponent bits per cell
	localparam int unsigned CELL_IDX_W = 4;
	localparam int unsigned BOARD_W = NUM_CELLS * TILE_W;

	// one cell's exponent
	typedef logic [TILE_W-1:0] tile_t;

	// cell number, cell 0 sits in the lowest bits of the board
	typedef logic [CELL_IDX_W-1:0] cell_idx_t;

	// all cells packed side by side
	typedef logic [BOARD_W-1:0] board_t;

	// game constants
	localparam tile_t EMPTY_TILE = tile_t'(0);
	localparam tile_t NEW_TILE = tile_t'(1); // spawned tile is a 2

endpackage

/* board_capture.sv */
`timescale 1ns/1ps

module board_capture
(
	input logic clock,
	input logic rst_n,
	input logic load,
	input tile_pkg::board_t board_in,
	input tile_pkg::cell_idx_t rand_cell,
	input logic spawn,
	output logic cap_valid,
	output tile_pkg::board_t cap_board,
	output tile_pkg::cell_idx_t cap_rand_cell,
	output logic cap_spawn
);

	// strobe follows load by one cycle
	always_ff @(posedge clock)
	begin
		if (!rst_n)
			cap_valid <= 1'b0;
		else
			cap_valid <= load;
	end

	// request fields are held until the next load
	always_ff @(posedge clock)
	begin
		if (!rst_n)
		begin
			cap_board <= '0;
			cap_rand_cell <= '0;
			cap_spawn <= 1'b0;
		end
		else if (load)
		begin
			cap_board <= board_in;
			cap_rand_cell <= rand_cell;
			cap_spawn <= spawn;
		end
	end

	// no capture strobe without a load one cycle earlier
	a_cap_follows_load: assert property (@(posedge clock) disable iff (!rst_n)
		$past(rst_n) && cap_valid |-> $past(load))
		else $error("cap_valid raised without a preceding load");

endmodule

/* spawn_chooser.sv */
`timescale 1ns/1ps

module spawn_chooser
(
	input logic clock,
	input logic rst_n,
	input logic cap_valid,
	input tile_pkg::board_t cap_board,
	input tile_pkg::cell_idx_t cap_rand_cell,
	input logic cap_spawn,
	output logic dec_valid,
	output tile_pkg::board_t dec_board,
	output logic dec_placed,
	output tile_pkg::cell_idx_t dec_cell,
	output logic dec_full
);
	import tile_pkg::*;

	tile_t cells [NUM_CELLS];
	logic [NUM_CELLS-1:0] empty_mask;
	logic rand_hit;
	logic any_empty;
	cell_idx_t first_empty;
	logic place_now;
	cell_idx_t chosen_cell;

	// split the board and flag empty cells
	always_comb
	begin
		for (int i = 0; i < NUM_CELLS; i++)
		begin
			cells[i] = cap_board[i*TILE_W +: TILE_W];
			empty_mask[i] = (cells[i] == EMPTY_TILE);
		end
	end

	assign rand_hit = empty_mask[cap_rand_cell]; // random cell is free
	assign any_empty = |empty_mask;

	// lowest numbered empty cell wins
	always_comb
	begin
		logic found;
		found = 1'b0;
		first_empty = '0;
		for (int i = 0; i < NUM_CELLS; i++)
		begin
			if (empty_mask[i] && !found)
			begin
				first_empty = cell_idx_t'(i);
				found = 1'b1;
			end
		end
	end

	assign place_now = cap_spawn && any_empty;

	always_comb
	begin
		if (!place_now)
			chosen_cell = '0;
		else if (rand_hit)
			chosen_cell = cap_rand_cell;
		else
			chosen_cell = first_empty; // fallback scan result
	end

	always_ff @(posedge clock)
	begin
		if (!rst_n)
			dec_valid <= 1'b0;
		else
			dec_valid <= cap_valid;
	end

	always_ff @(posedge clock)
	begin
		if (!rst_n)
		begin
			dec_board <= '0;
			dec_placed <= 1'b0;
			dec_cell <= '0;
			dec_full <= 1'b0;
		end
		else if (cap_valid)
		begin
			dec_board <= cap_board;
			dec_placed <= place_now;
			dec_cell <= chosen_cell;
			dec_full <= !any_empty; // reported even with spawn off
		end
	end

	// a spawn only ever targets a free cell
	a_target_empty: assert property (@(posedge clock) disable iff (!rst_n)
		dec_valid && dec_placed |->
			dec_board[int'(dec_cell)*TILE_W +: TILE_W] == EMPTY_TILE)
		else $error("spawn chosen for an occupied cell");

	// a full board never takes a tile
	a_placed_not_full: assert property (@(posedge clock) disable iff (!rst_n)
		dec_valid |-> !(dec_placed && dec_full))
		else $error("placed and full raised together");

endmodule

/* board_writer.sv */
`timescale 1ns/1ps

module board_writer
(
	input logic clock,
	input logic rst_n,
	input logic dec_valid,
	input tile_pkg::board_t dec_board,
	input logic dec_placed,
	input tile_pkg::cell_idx_t dec_cell,
	input logic dec_full,
	output logic out_valid,
	output tile_pkg::board_t board_out,
	output logic placed,
	output tile_pkg::cell_idx_t placed_cell,
	output logic full
);
	import tile_pkg::*;

	logic [NUM_CELLS-1:0] wr_en;
	board_t next_board;

	// cells whose contents differ between two boards
	function automatic logic [NUM_CELLS-1:0] cell_diff(board_t a, board_t b);
		logic [NUM_CELLS-1:0] d;
		for (int i = 0; i < NUM_CELLS; i++)
			d[i] = (a[i*TILE_W +: TILE_W] != b[i*TILE_W +: TILE_W]);
		return d;
	endfunction

	// one-hot cell write enable
	always_comb
	begin
		wr_en = '0;
		if (dec_placed)
			wr_en[dec_cell] = 1'b1;
	end

	always_comb
	begin
		for (int i = 0; i < NUM_CELLS; i++)
		begin
			if (wr_en[i])
				next_board[i*TILE_W +: TILE_W] = NEW_TILE;
			else
				next_board[i*TILE_W +: TILE_W] = dec_board[i*TILE_W +: TILE_W];
		end
	end

	always_ff @(posedge clock)
	begin
		if (!rst_n)
			out_valid <= 1'b0;
		else
			out_valid <= dec_valid;
	end

	// outputs hold between strobes
	always_ff @(posedge clock)
	begin
		if (!rst_n)
		begin
			board_out <= '0;
			placed <= 1'b0;
			placed_cell <= '0;
			full <= 1'b0;
		end
		else if (dec_valid)
		begin
			board_out <= next_board;
			placed <= dec_placed;
			placed_cell <= dec_cell;
			full <= dec_full;
		end
	end

	// the write touches one cell at most
	a_one_cell: assert property (@(posedge clock) disable iff (!rst_n)
		$past(rst_n) && out_valid |->
			$countones(cell_diff(board_out, $past(dec_board))) <= 1)
		else $error("more than one cell changed");

	// and that cell is the one reported
	a_changed_is_reported: assert property (@(posedge clock) disable iff (!rst_n)
		$past(rst_n) && out_valid && placed |->
			cell_diff(board_out, $past(dec_board)) == (NUM_CELLS'(1) << placed_cell))
		else $error("changed cell differs from placed_cell");

endmodule

/* tile_spawner_top.sv */
`timescale 1ns/1ps

module tile_spawner_top
(
	input logic clock,
	input logic rst_n,
	input logic load,
	input tile_pkg::board_t board_in,
	input tile_pkg::cell_idx_t rand_cell,
	input logic spawn,
	output logic out_valid,
	output tile_pkg::board_t board_out,
	output logic placed,
	output tile_pkg::cell_idx_t placed_cell,
	output logic full
);
	import tile_pkg::*;

	// capture to chooser
	logic cap_valid;
	board_t cap_board;
	cell_idx_t cap_rand_cell;
	logic cap_spawn;

	// chooser to writer
	logic dec_valid;
	board_t dec_board;
	logic dec_placed;
	cell_idx_t dec_cell;
	logic dec_full;

	board_capture board_capture_i
	(
		.clock(clock),
		.rst_n(rst_n),
		.load(load),
		.board_in(board_in),
		.rand_cell(rand_cell),
		.spawn(spawn),
		.cap_valid(cap_valid),
		.cap_board(cap_board),
		.cap_rand_cell(cap_rand_cell),
		.cap_spawn(cap_spawn)
	);

	spawn_chooser spawn_chooser_i
	(
		.clock(clock),
		.rst_n(rst_n),
		.cap_valid(cap_valid),
		.cap_board(cap_board),
		.cap_rand_cell(cap_rand_cell),
		.cap_spawn(cap_spawn),
		.dec_valid(dec_valid),
		.dec_board(dec_board),
		.dec_placed(dec_placed),
		.dec_cell(dec_cell),
		.dec_full(dec_full)
	);

	board_writer board_writer_i
	(
		.clock(clock),
		.rst_n(rst_n),
		.dec_valid(dec_valid),
		.dec_board(dec_board),
		.dec_placed(dec_placed),
		.dec_cell(dec_cell),
		.dec_full(dec_full),
		.out_valid(out_valid),
		.board_out(board_out),
		.placed(placed),
		.placed_cell(placed_cell),
		.full(full)
	);

endmodule

/* tile_spawner_tb.sv */
`timescale 1ns/1ps

module tile_spawner_tb;
	import tile_pkg::*;

	localparam string PATTERN_FILE = "spawn_patterns.txt";
	localparam int CLOCK_HALF = 50; // 100 ns period
	localparam int RESET_CYCLES = 16;
	localparam int LATENCY = 3;
	localparam int TIMEOUT_MARGIN = 20;

	logic clock;
	logic rst_n;
	logic load;
	board_t board_in;
	cell_idx_t rand_cell;
	logic spawn;
	logic out_valid;
	board_t board_out;
	logic placed;
	cell_idx_t placed_cell;
	logic full;

	// patterns as read from the file
	int gap_q[$];
	logic spawn_q[$];
	cell_idx_t rand_q[$];
	board_t board_q[$];
	board_t want_board_q[$];
	logic want_placed_q[$];
	cell_idx_t want_cell_q[$];
	logic want_full_q[$];

	// loads waiting for their output
	int pend_idx_q[$];
	int pend_cycle_q[$];

	int cycle_count = 0;
	int timeout_limit = 0;
	int num_patterns = 0;
	int checked_count = 0;

	tile_spawner_top tile_spawner_top_i
	(
		.clock(clock),
		.rst_n(rst_n),
		.load(load),
		.board_in(board_in),
		.rand_cell(rand_cell),
		.spawn(spawn),
		.out_valid(out_valid),
		.board_out(board_out),
		.placed(placed),
		.placed_cell(placed_cell),
		.full(full)
	);

	initial
		clock = 1'b0;

	always #(CLOCK_HALF) clock = ~clock;

	task automatic abort_run();
		$display("FAIL: see errors above");
		$fatal(1, "simulation stopped");
	endtask

	task automatic report_mismatch(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		$display("CHECK FAILED %s: expected %0h, actual %0h", name, expected, actual);
		abort_run();
	endtask

	task automatic read_patterns();
		int fd;
		int fields;
		int gap;
		logic sp;
		cell_idx_t rc;
		board_t b_in;
		board_t b_want;
		logic p_want;
		cell_idx_t c_want;
		logic f_want;
		string line;
		fd = $fopen(PATTERN_FILE, "r");
		if (fd == 0)
		begin
			$display("ERROR: could not open pattern file %s", PATTERN_FILE);
			abort_run();
		end
		while ($fgets(line, fd) > 0)
		begin
			if (line.getc(0) == "#")
				continue; // column description
			fields = $sscanf(line, "%d %h %h %h %h %h %h %h", gap, sp, rc, b_in, b_want,
				p_want, c_want, f_want);
			if (fields <= 0)
				continue;
			if (fields != 8)
			begin
				$display("ERROR: malformed pattern line: %s", line);
				abort_run();
			end
			gap_q.push_back(gap);
			spawn_q.push_back(sp);
			rand_q.push_back(rc);
			board_q.push_back(b_in);
			want_board_q.push_back(b_want);
			want_placed_q.push_back(p_want);
			want_cell_q.push_back(c_want);
			want_full_q.push_back(f_want);
		end
		$fclose(fd);
		num_patterns = gap_q.size();
	endtask

	task automatic check_idle();
		assert (out_valid === 1'b0) else report_mismatch("reset out_valid", 0, out_valid);
		assert (placed === 1'b0) else report_mismatch("reset placed", 0, placed);
		assert (full === 1'b0) else report_mismatch("reset full", 0, full);
	endtask

	task automatic check_output();
		int idx;
		int load_cycle;
		idx = pend_idx_q.pop_front();
		load_cycle = pend_cycle_q.pop_front();
		assert (cycle_count - load_cycle == LATENCY)
			else report_mismatch($sformatf("pattern %0d latency", idx), LATENCY,
				cycle_count - load_cycle);
		assert (board_out === want_board_q[idx])
			else report_mismatch($sformatf("pattern %0d board_out", idx), want_board_q[idx],
				board_out);
		assert (placed === want_placed_q[idx])
			else report_mismatch($sformatf("pattern %0d placed", idx), want_placed_q[idx],
				placed);
		assert (placed_cell === want_cell_q[idx])
			else report_mismatch($sformatf("pattern %0d placed_cell", idx), want_cell_q[idx],
				placed_cell);
		assert (full === want_full_q[idx])
			else report_mismatch($sformatf("pattern %0d full", idx), want_full_q[idx], full);
		checked_count++;
	endtask

	// one load on the current falling edge, then its idle gap
	task automatic apply_pattern(input int idx);
		load = 1'b1;
		spawn = spawn_q[idx];
		rand_cell = rand_q[idx];
		board_in = board_q[idx];
		pend_idx_q.push_back(idx);
		pend_cycle_q.push_back(cycle_count);
		@(negedge clock);
		load = 1'b0;
		repeat (gap_q[idx]) @(negedge clock);
	endtask

	always @(posedge clock)
	begin
		cycle_count <= cycle_count + 1;
		if (timeout_limit != 0 && cycle_count >= timeout_limit)
		begin
			$display("ERROR: timeout after %0d cycles, %0d of %0d outputs arrived",
				cycle_count, checked_count, num_patterns);
			abort_run();
		end
	end

	always @(posedge clock)
	begin
		if (rst_n && out_valid)
		begin
			if (pend_idx_q.size() == 0)
			begin
				$display("ERROR: unexpected output with no load pending");
				abort_run();
			end
			else
				check_output();
		end
	end

	initial
	begin
		int total;
		rst_n = 1'b0;
		load = 1'b0;
		spawn = 1'b0;
		rand_cell = '0;
		board_in = '0;
		read_patterns();
		if (num_patterns == 0)
		begin
			$display("ERROR: no patterns found in %s", PATTERN_FILE);
			abort_run();
		end
		total = 0;
		foreach (gap_q[i])
			total += 1 + gap_q[i];
		timeout_limit = RESET_CYCLES + total + LATENCY + TIMEOUT_MARGIN;
		repeat (RESET_CYCLES) @(negedge clock);
		rst_n = 1'b1;
		check_idle();
		for (int i = 0; i < num_patterns; i++)
			apply_pattern(i);
		wait (checked_count == num_patterns);
		repeat (LATENCY + 2) @(negedge clock); // catch stray strobes
		if (checked_count == num_patterns && pend_idx_q.size() == 0)
		begin
			$display("PASS: all tests");
			$finish;
		end
		else
		begin
			$display("ERROR: %0d outputs checked for %0d loads", checked_count, num_patterns);
			abort_run();
		end
	end

endmodule

/* spawn_patterns.txt */
# gap spawn rand_cell board_in exp_board_out exp_placed exp_placed_cell exp_full
# gap is decimal idle cycles after the load, the rest is hex, cell 0 is the rightmost digit
# random hit
4 1 0 0000000000000000 0000000000000001 1 0 0
4 1 f 0000000000000000 1000000000000000 1 f 0
4 1 9 1234000056780000 1234001056780000 1 9 0
4 1 7 2222222202222222 2222222212222222 1 7 0
4 1 9 abcdef0123456789 abcdef1123456789 1 9 0
4 1 3 0f0f0f0f0f0f0f0f 0f0f0f0f0f0f1f0f 1 3 0
# first-empty fallback
4 1 0 0000000000000001 0000000000000011 1 1 0
4 1 0 0fffffffffffffff 1fffffffffffffff 1 f 0
4 1 7 0fffffffffffffff 1fffffffffffffff 1 f 0
4 1 4 1234000056780000 1234000056780001 1 0 0
4 1 2 0f0f0f0f0f0f0f0f 0f0f0f0f0f0f0f1f 1 1 0
4 1 0 abcdef0123456789 abcdef1123456789 1 9 0
4 1 3 0000000011111111 0000000111111111 1 8 0
4 1 0 0033003300330033 0033003300330133 1 2 0
# full board
4 1 5 1234567812345678 1234567812345678 0 0 1
4 0 5 1234567812345678 1234567812345678 0 0 1
4 1 0 ffffffffffffffff ffffffffffffffff 0 0 1
4 0 a 1111111111111111 1111111111111111 0 0 1
4 1 f abcdef123456789a abcdef123456789a 0 0 1
# pass-through
4 0 0 0000000000000000 0000000000000000 0 0 0
4 0 9 1234000056780000 1234000056780000 0 0 0
4 0 0 0fffffffffffffff 0fffffffffffffff 0 0 0
4 0 3 0f0f0f0f0f0f0f0f 0f0f0f0f0f0f0f0f 0 0 0
# back-to-back mixed run
0 1 5 0000000000000000 0000000000100000 1 5 0
0 1 5 0000000000100000 0000000000100001 1 0 0
0 1 0 0000000000100001 0000000000100011 1 1 0
0 0 2 1234567812345678 1234567812345678 0 0 1
0 1 c 0000000000100011 0001000000100011 1 c 0
0 0 1 0001000000100011 0001000000100011 0 0 0
0 1 0 0fffffffffffffff 1fffffffffffffff 1 f 0
0 1 f 1fffffffffffffff 1fffffffffffffff 0 0 1
0 1 8 5555555505555555 5555555515555555 1 7 0
0 1 7 5555555505555555 5555555515555555 1 7 0
0 1 2 9090909090909090 9090909090909190 1 2 0
0 1 3 9090909090909090 9090909090909091 1 0 0
0 0 f 9090909090909090 9090909090909090 0 0 0
0 1 b 0000000000000000 0000100000000000 1 b 0
0 1 e 7000000000000000 7100000000000000 1 e 0
0 1 f 7000000000000000 7000000000000001 1 0 0
0 1 4 cccccccccccccccc cccccccccccccccc 0 0 1
0 1 6 00ee00ee00ee00ee 00ee00ee01ee00ee 1 6 0
0 1 5 00ee00ee00ee00ee 00ee00ee00ee01ee 1 2 0
0 0 0 ffffffffffffffff ffffffffffffffff 0 0 1
3 1 d 8888888888888880 8888888888888881 1 0 0
# short gaps
1 1 1 0000000000000000 0000000000000010 1 1 0
1 1 1 0000000000000010 0000000000000011 1 0 0
1 1 1 0000000000000011 0000000000000111 1 2 0
2 1 9 0000000000000111 0000001000000111 1 9 0
5 1 0 6543210fedcba987 6543211fedcba987 1 9 0
5 1 f 6543210fedcba987 6543211fedcba987 1 9 0

/* tile_spawner.f */
tile_pkg.sv
board_capture.sv
spawn_chooser.sv
board_writer.sv
tile_spawner_top.sv
tile_spawner_tb.sv
